// ==== flist.f ====
rtl/permPkg.sv
rtl/syncFifo.sv
rtl/laneDispatcher.sv
rtl/permLane.sv
rtl/topManager.sv
rtl/resultGatherer.sv
rtl/permTop.sv
verification/permTop_properties.sv
verification/permChecker.sv
verification/permTb.sv

// ==== rtl/laneDispatcher.sv ====
`timescale 1ns/1ps

module laneDispatcher import permPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     accept,
    input  laneMaskT laneFull,
    output laneMaskT select,
    output logic     almostFull
);

    logic [1:0] channelBlocked;

    for (genvar c = 0; c < 2; c++) begin : channelGen
        logic [LANES_PER_CHANNEL-1:0] ptr;
        logic [LANES_PER_CHANNEL-1:0] nextPtr;
        logic [LANES_PER_CHANNEL-1:0] chanFull;

        assign chanFull = laneFull[c*LANES_PER_CHANNEL +: LANES_PER_CHANNEL];
        assign channelBlocked[c] = &chanFull;
        assign select[c*LANES_PER_CHANNEL +: LANES_PER_CHANNEL] = ptr;

        // Nearest lane in rotation order that still has room
        always_comb begin
            logic [LANES_PER_CHANNEL-1:0] cand;
            logic found;
            nextPtr = ptr;
            cand = ptr;
            found = 1'b0;
            for (int k = 1; k < LANES_PER_CHANNEL; k++) begin
                cand = {cand[LANES_PER_CHANNEL-2:0], cand[LANES_PER_CHANNEL-1]};
                if (!found && |(cand & ~chanFull)) begin
                    nextPtr = cand;
                    found = 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ptr <= LANES_PER_CHANNEL'(1);
            end else if (accept) begin
                ptr <= nextPtr;
            end
        end
    end

    // Stop input once a whole channel has no room left
    assign almostFull = |channelBlocked;

endmodule

// ==== rtl/permLane.sv ====
`timescale 1ns/1ps

module permLane import permPkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [OPERAND_WIDTH-1:0] bot,
    input  logic [OPERAND_WIDTH-1:0] top,
    input  logic                     write,
    input  logic                     read,
    output laneResultT               result,
    output logic                     empty,
    output logic                     almostFull
);

    laneResultT stage [KERNEL_LATENCY];
    logic [KERNEL_LATENCY-1:0] stageValid;
    laneResultT kernelOut;

    function automatic logic [COUNT_WIDTH-1:0] popCount(input logic [OPERAND_WIDTH-1:0] value);
        logic [COUNT_WIDTH-1:0] total;
        total = '0;
        for (int b = 0; b < OPERAND_WIDTH; b++) begin
            total = total + value[b];
        end
        return total;
    endfunction

    // Stand-in kernel
    assign kernelOut.overlap = popCount(bot & top);
    assign kernelOut.distance = popCount(bot ^ top);

    always_ff @(posedge clk) begin
        stage[0] <= kernelOut;
        for (int s = 1; s < KERNEL_LATENCY; s++) begin
            stage[s] <= stage[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[KERNEL_LATENCY-2:0], write};
        end
    end

    // Margin covers whatever is still inside the pipeline
    syncFifo #(
        .WIDTH($bits(laneResultT)),
        .DEPTH_LOG2(LANE_FIFO_DEPTH_LOG2),
        .MARGIN(LANE_FIFO_MARGIN)
    ) laneFifo (
        .clk(clk),
        .rst(rst),
        .write(stageValid[KERNEL_LATENCY-1]),
        .dataIn(stage[KERNEL_LATENCY-1]),
        .read(read),
        .dataOut(result),
        .empty(empty),
        .almostFull(almostFull)
    );

endmodule

// ==== rtl/permPkg.sv ====
package permPkg;

    // Operand and lane geometry
    localparam int OPERAND_WIDTH = 64;
    localparam int LANES_PER_CHANNEL = 2;
    localparam int LANE_COUNT = 2 * LANES_PER_CHANNEL;
    localparam int KERNEL_LATENCY = 6;

    // Buffer sizing
    localparam int LANE_FIFO_DEPTH_LOG2 = 4;
    localparam int LANE_FIFO_MARGIN = 8;
    localparam int ORIGIN_DEPTH_LOG2 = 6;
    localparam int OUT_FIFO_DEPTH_LOG2 = 4;
    localparam int OUT_FIFO_MARGIN = 4;

    // Idle cycles before the lanes count as empty
    localparam int DRAIN_CYCLES = 12;

    // Wide enough for a count of 0..64
    localparam int COUNT_WIDTH = 7;

    typedef struct packed {
        logic [OPERAND_WIDTH-1:0] botA;
        logic [OPERAND_WIDTH-1:0] botB;
    } botPairT;

    typedef struct packed {
        logic [OPERAND_WIDTH-1:0] top;
        logic [OPERAND_WIDTH-1:0] reserved;
    } topWordT;

    // Host word, meaning depends on the newTop flag
    typedef union packed {
        botPairT botPair;
        topWordT topWord;
    } hostWordT;

    typedef struct packed {
        logic [COUNT_WIDTH-1:0] overlap;
        logic [COUNT_WIDTH-1:0] distance;
    } laneResultT;

    typedef struct packed {
        laneResultT resA;
        laneResultT resB;
    } pairResultT;

    // Channel A lanes in the low half, channel B in the high half
    typedef logic [LANE_COUNT-1:0] laneMaskT;

endpackage

// ==== rtl/permTop.sv ====
`timescale 1ns/1ps

module permTop import permPkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  hostWordT                    data,
    input  logic                        newTop,
    input  logic                        inValid,
    output logic                        inReady,
    output logic [$bits(hostWordT)-1:0] results,
    input  logic                        outReady,
    output logic                        outValid
);

    logic accepted;
    logic botAccept;
    logic topWrite;
    laneMaskT select;
    laneMaskT laneAlmostFull;
    laneMaskT laneEmpty;
    laneMaskT laneRead;
    laneResultT laneResults [LANE_COUNT];
    logic dispAlmostFull;
    logic stall;
    logic drained;
    logic [OPERAND_WIDTH-1:0] curTop;
    pairResultT pairOut;
    pairResultT outPair;
    logic pairValid;
    logic outEmpty;
    logic outAlmostFull;

    assign inReady = !rst && !dispAlmostFull && !stall;
    assign accepted = inValid && inReady;
    assign botAccept = accepted && !newTop;
    assign topWrite = accepted && newTop;

    laneDispatcher dispatcher (
        .clk(clk),
        .rst(rst),
        .accept(botAccept),
        .laneFull(laneAlmostFull),
        .select(select),
        .almostFull(dispAlmostFull)
    );

    for (genvar i = 0; i < LANE_COUNT; i++) begin : laneGen
        logic [OPERAND_WIDTH-1:0] laneBot;

        // Low lanes serve channel A
        assign laneBot = (i < LANES_PER_CHANNEL) ? data.botPair.botA : data.botPair.botB;

        permLane lane (
            .clk(clk),
            .rst(rst),
            .bot(laneBot),
            .top(curTop),
            .write(botAccept && select[i]),
            .read(laneRead[i]),
            .result(laneResults[i]),
            .empty(laneEmpty[i]),
            .almostFull(laneAlmostFull[i])
        );
    end

    topManager topMgr (
        .clk(clk),
        .rst(rst),
        .topWrite(topWrite),
        .topIn(data.topWord.top),
        .drained(drained),
        .stall(stall),
        .top(curTop)
    );

    resultGatherer gatherer (
        .clk(clk),
        .rst(rst),
        .accept(botAccept),
        .select(select),
        .laneEmpty(laneEmpty),
        .laneResults(laneResults),
        .laneRead(laneRead),
        .outFull(outAlmostFull),
        .pairOut(pairOut),
        .pairValid(pairValid),
        .drained(drained)
    );

    // Margin absorbs the two gather stages in flight
    syncFifo #(
        .WIDTH($bits(pairResultT)),
        .DEPTH_LOG2(OUT_FIFO_DEPTH_LOG2),
        .MARGIN(OUT_FIFO_MARGIN)
    ) outFifo (
        .clk(clk),
        .rst(rst),
        .write(pairValid),
        .dataIn(pairOut),
        .read(outValid && outReady),
        .dataOut(outPair),
        .empty(outEmpty),
        .almostFull(outAlmostFull)
    );

    assign outValid = !outEmpty;
    assign results = {{($bits(hostWordT) - $bits(pairResultT)){1'b0}}, outPair};

endmodule

// ==== rtl/resultGatherer.sv ====
`timescale 1ns/1ps

module resultGatherer import permPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       accept,
    input  laneMaskT   select,
    input  laneMaskT   laneEmpty,
    input  laneResultT laneResults [LANE_COUNT],
    output laneMaskT   laneRead,
    input  logic       outFull,
    output pairResultT pairOut,
    output logic       pairValid,
    output logic       drained
);

    laneMaskT headMask;
    logic originEmpty;
    logic grab;
    logic grabD;
    laneResultT maskedRes [LANE_COUNT];
    laneResultT pickA;
    laneResultT pickB;
    logic [$clog2(DRAIN_CYCLES + 1)-1:0] idleCount;

    // Records which lanes got each pair, in input order
    syncFifo #(
        .WIDTH(LANE_COUNT),
        .DEPTH_LOG2(ORIGIN_DEPTH_LOG2)
    ) originQueue (
        .clk(clk),
        .rst(rst),
        .write(accept),
        .dataIn(select),
        .read(grab),
        .dataOut(headMask),
        .empty(originEmpty),
        .almostFull()
    );

    // Both lanes of the head entry must hold data
    assign grab = !originEmpty && ((headMask & laneEmpty) == '0) && !outFull;
    assign laneRead = grab ? headMask : '0;

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANE_COUNT; i++) begin
            maskedRes[i] <= laneRead[i] ? laneResults[i] : '0;
        end
    end

    // Only one lane per channel is non-zero
    always_comb begin
        pickA = '0;
        pickB = '0;
        for (int i = 0; i < LANES_PER_CHANNEL; i++) begin
            pickA = pickA | maskedRes[i];
            pickB = pickB | maskedRes[LANES_PER_CHANNEL + i];
        end
    end

    always_ff @(posedge clk) begin
        pairOut.resA <= pickA;
        pairOut.resB <= pickB;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grabD <= 1'b0;
            pairValid <= 1'b0;
        end else begin
            grabD <= grab;
            pairValid <= grabD;
        end
    end

    // Idle counter, restarts on any outstanding work
    assign drained = (idleCount == DRAIN_CYCLES);

    always_ff @(posedge clk) begin
        if (rst || !originEmpty || accept) begin
            idleCount <= '0;
        end else if (!drained) begin
            idleCount <= idleCount + 1'b1;
        end
    end

endmodule

// ==== rtl/syncFifo.sv ====
`timescale 1ns/1ps

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4,
    parameter int MARGIN = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             write,
    input  logic [WIDTH-1:0] dataIn,
    input  logic             read,
    output logic [WIDTH-1:0] dataOut,
    output logic             empty,
    output logic             almostFull
);

    logic [WIDTH-1:0] mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0] count;
    logic doWrite;
    logic doRead;

    // Guard against reading an empty or writing a full buffer
    assign doRead = read && !empty;
    assign doWrite = write && (count < 2**DEPTH_LOG2);

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word is visible without a read
    assign dataOut = mem[rdPtr];
    assign empty = (count == '0);
    assign almostFull = (2**DEPTH_LOG2 - count) <= MARGIN;

endmodule

// ==== rtl/topManager.sv ====
`timescale 1ns/1ps

module topManager import permPkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     topWrite,
    input  logic [OPERAND_WIDTH-1:0] topIn,
    input  logic                     drained,
    output logic                     stall,
    output logic [OPERAND_WIDTH-1:0] top
);

    logic [OPERAND_WIDTH-1:0] pendingTop;

    // Held here until the old bottoms are out of the lanes
    always_ff @(posedge clk) begin
        if (topWrite) begin
            pendingTop <= topIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stall <= 1'b0;
        end else if (topWrite) begin
            stall <= 1'b1;
        end else if (stall && drained) begin
            stall <= 1'b0;
        end
    end

    // Lanes see the new top only once nothing old is in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else if (stall && drained) begin
            top <= pendingTop;
        end
    end

endmodule

// ==== verification/permChecker.sv ====
`timescale 1ns/1ps

module permChecker import permPkg::*; (
    input logic                        clk,
    input logic                        rst,
    input logic [$bits(hostWordT)-1:0] results,
    input logic                        outValid,
    input logic                        outReady,
    input logic                        inValid,
    input logic                        inReady
);

    localparam int PAD_WIDTH = $bits(hostWordT) - $bits(pairResultT);

    pairResultT expected [$];
    int errorCount = 0;
    int resultCount = 0;
    int stallCycles = 0;

    task automatic expectPair(input pairResultT pair);
        expected.push_back(pair);
    endtask

    task automatic noteFailure(input string msg);
        errorCount++;
        $display("%s", msg);
    endtask

    // Outputs are sampled on the rising edge, before the DUT registers update
    always @(posedge clk) begin
        pairResultT want;
        if (!rst && outValid && outReady) begin
            if (expected.size() == 0) begin
                noteFailure("Output word arrived with no pair left to match it");
            end else begin
                want = expected.pop_front();
                if (results !== {{PAD_WIDTH{1'b0}}, want}) begin
                    errorCount++;
                    $display("** Error at %0t: result %0d is %h, expected %h",
                             $time, resultCount, results, {{PAD_WIDTH{1'b0}}, want});
                end
            end
            resultCount++;
        end
        // Input offered but refused
        if (!rst && inValid && !inReady) begin
            stallCycles++;
        end
    end

endmodule

// ==== verification/permTb.sv ====
`timescale 1ns/1ps

module permTb import permPkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int TOTAL_WORDS = 201 + 150 + 101 + 56 + 60;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 2000;

    logic clk;
    logic rst;
    hostWordT data;
    logic newTop;
    logic inValid;
    logic inReady;
    logic [$bits(hostWordT)-1:0] results;
    logic outReady;
    logic outValid;

    int seed = 29;
    // Separate stream so output pacing does not shift the stimulus
    int readySeed = 29;
    int readyMode = 0;
    int acceptedPairs = 0;
    int stallsBefore;
    int failures;
    logic [OPERAND_WIDTH-1:0] refTop = '0;

    permTop DUT (
        .clk(clk),
        .rst(rst),
        .data(data),
        .newTop(newTop),
        .inValid(inValid),
        .inReady(inReady),
        .results(results),
        .outReady(outReady),
        .outValid(outValid)
    );

    permChecker resultCheck (
        .clk(clk),
        .rst(rst),
        .results(results),
        .outValid(outValid),
        .outReady(outReady),
        .inValid(inValid),
        .inReady(inReady)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bit counts taken straight from the definitions of overlap and distance
    function automatic pairResultT expectedPair(input logic [OPERAND_WIDTH-1:0] botA,
                                                input logic [OPERAND_WIDTH-1:0] botB,
                                                input logic [OPERAND_WIDTH-1:0] topVal);
        pairResultT pair;
        pair.resA.overlap = COUNT_WIDTH'($countones(botA & topVal));
        pair.resA.distance = COUNT_WIDTH'($countones(botA ^ topVal));
        pair.resB.overlap = COUNT_WIDTH'($countones(botB & topVal));
        pair.resB.distance = COUNT_WIDTH'($countones(botB ^ topVal));
        return pair;
    endfunction

    function automatic logic [OPERAND_WIDTH-1:0] randomOperand();
        return {$random(seed), $random(seed)};
    endfunction

    // Called on a falling edge, returns on the falling edge after the accept
    task automatic sendWord(input hostWordT word, input logic isTop);
        if (($random(seed) & 3) == 0) begin
            @(negedge clk);
        end
        data = word;
        newTop = isTop;
        inValid = 1'b1;
        // inReady only moves on rising edges, so it is settled here
        while (!inReady) begin
            @(negedge clk);
        end
        if (isTop) begin
            refTop = word.topWord.top;
        end else begin
            resultCheck.expectPair(expectedPair(word.botPair.botA, word.botPair.botB, refTop));
            acceptedPairs++;
        end
        @(negedge clk);
        inValid = 1'b0;
        newTop = 1'b0;
    endtask

    task automatic sendPairs(input int count);
        hostWordT word;
        for (int n = 0; n < count; n++) begin
            word.botPair.botA = randomOperand();
            word.botPair.botB = randomOperand();
            sendWord(word, 1'b0);
        end
    endtask

    task automatic sendTop();
        hostWordT word;
        word.topWord.top = randomOperand();
        // Reserved bits carry noise, the DUT must ignore them
        word.topWord.reserved = randomOperand();
        sendWord(word, 1'b1);
    endtask

    // Output pacing: 0 always ready, 1 random with long holds, 2 long block
    initial begin
        int holdLeft;
        int prevMode;
        outReady = 1'b0;
        holdLeft = 0;
        prevMode = 0;
        forever begin
            @(negedge clk);
            if (readyMode != prevMode) begin
                holdLeft = (readyMode == 2) ? 400 : ((readyMode == 1) ? 50 : 0);
            end
            prevMode = readyMode;
            if (holdLeft > 0) begin
                outReady = 1'b0;
                holdLeft--;
            end else if (readyMode == 1) begin
                if (($random(readySeed) & 63) == 0) begin
                    holdLeft = 50;
                end
                outReady = 1'($random(readySeed) & 1);
            end else begin
                outReady = 1'b1;
            end
        end
    end

    initial begin
        rst = 1'b1;
        data = '0;
        newTop = 1'b0;
        inValid = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // One top, then a long stream with a free output
        sendTop();
        sendPairs(200);

        // Random output pacing
        readyMode = 1;
        sendPairs(150);

        // Top change in the middle of the stream
        readyMode = 0;
        sendPairs(50);
        sendTop();
        sendPairs(50);

        // Several tops, two of them back to back
        readyMode = 1;
        repeat (4) begin
            sendTop();
            sendPairs(10);
        end
        sendTop();
        sendTop();
        sendPairs(10);

        // Burst into a blocked output, input has to stall
        stallsBefore = resultCheck.stallCycles;
        readyMode = 2;
        sendPairs(60);
        if (resultCheck.stallCycles == stallsBefore) begin
            resultCheck.noteFailure("inReady never fell while the output was blocked");
        end

        while (resultCheck.resultCount < acceptedPairs) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        if (resultCheck.resultCount != acceptedPairs) begin
            resultCheck.noteFailure("Number of results differs from number of accepted pairs");
        end

        failures = resultCheck.errorCount + DUT.props.assertFailures;
        $display("Summary: %0d pairs, %0d results, %0d stalls, %0d errors, %0d assert fails",
                 acceptedPairs, resultCheck.resultCount, resultCheck.stallCycles,
                 resultCheck.errorCount, DUT.props.assertFailures);
        if (failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== verification/permTop_properties.sv ====
`timescale 1ns/1ps

module permTopProperties import permPkg::*; (
    input logic                        clk,
    input logic                        rst,
    input logic                        inReady,
    input logic                        outValid,
    input logic                        outReady,
    input logic [$bits(hostWordT)-1:0] results
);

    int assertFailures = 0;

    // A stalled output word must not change under the host
    property resultsHeld;
        @(posedge clk) disable iff (rst)
            (outValid && !outReady) |=> (outValid && $stable(results));
    endproperty

    property noInputInReset;
        @(posedge clk) rst |-> !inReady;
    endproperty

    property outputIdleAfterReset;
        @(posedge clk) rst |=> !outValid;
    endproperty

    resultsHeldCheck: assert property (resultsHeld)
        else begin
            $error("Output word changed while stalled");
            assertFailures++;
        end

    noInputInResetCheck: assert property (noInputInReset)
        else begin
            $error("inReady high during reset");
            assertFailures++;
        end

    outputIdleCheck: assert property (outputIdleAfterReset)
        else begin
            $error("outValid high right after reset");
            assertFailures++;
        end

endmodule

bind permTop permTopProperties props (
    .clk(clk),
    .rst(rst),
    .inReady(inReady),
    .outValid(outValid),
    .outReady(outReady),
    .results(results)
);
